// ==== dispatch_stage.f ====
+incdir+common
common/ooo_pkg.sv
common/rs_dispatch_if.sv
src/inst_decoder.sv
src/map_table.sv
rob/reorder_buffer.sv
src/reservation_station.sv
src/regfile.sv
src/dispatch_stage.sv
test/dispatch_stage_props.sv
test/dispatch_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch stage testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f dispatch_stage.f \
        --top-module dispatch_stage_tb -o dispatch_stage_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dispatch_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
exit 0

// ==== test/dispatch_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage_tb import ooo_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_LEN     = 400;
    localparam int FAST_DELAY   = 2;
    localparam int SLOW_DELAY   = 14;
    // each instruction may wait out a full cdb delay plus stalls behind others
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * (SLOW_DELAY + 16) + 100;

    logic      clock;
    logic      rst;
    logic      inst_valid;
    word_t     inst;
    word_t     pc;
    logic      dispatch_ready;
    logic      fu_busy;
    logic      issue_valid;
    word_t     issue_opa;
    word_t     issue_opb;
    alu_func_t issue_func;
    rob_tag_t  issue_tag;
    logic      cdb_valid;
    rob_tag_t  cdb_tag;
    word_t     cdb_value;
    logic      retire_valid;
    reg_idx_t  retire_rd;
    word_t     retire_value;

    int errors = 0;
    int retire_count = 0;
    int n_legal = 0;
    int n_illegal = 0;
    logic slow = 1'b0;

    // shadow architectural state and retire expectations
    word_t    shadow [32] = '{default: '0};
    reg_idx_t exp_rd_q [$];
    word_t    exp_val_q [$];

    // results waiting for their cdb slot
    rob_tag_t res_tag_q [$];
    word_t    res_val_q [$];
    int       res_due_q [$];

    reg_idx_t recent [4] = '{5'd1, 5'd2, 5'd3, 5'd4};
    logic [1:0] recent_ptr = '0;

    dispatch_stage dut (
        .clock          (clock),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .dispatch_ready (dispatch_ready),
        .fu_busy        (fu_busy),
        .issue_valid    (issue_valid),
        .issue_opa      (issue_opa),
        .issue_opb      (issue_opb),
        .issue_func     (issue_func),
        .issue_tag      (issue_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .retire_valid   (retire_valid),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////
    // reference models
    ////////////////////////////////////////

    // rv32i semantics on the shadow registers
    function automatic word_t isa_result(input word_t w, input word_t pc_val);
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        logic       alt;
        a   = shadow[w[19:15]];
        b   = shadow[w[24:20]];
        f3  = w[14:12];
        alt = w[30];
        case (w[6:0])
            7'b0110111: return {w[31:12], 12'b0};
            7'b0010111: return pc_val + {w[31:12], 12'b0};
            7'b0010011: begin
                b   = {{20{w[31]}}, w[31:20]};
                alt = alt && (f3 == 3'b101);
            end
            default: ;
        endcase
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return word_t'($signed(a) < $signed(b));
            3'b011:  return word_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // what the external unit computes for an issued operation
    function automatic word_t alu_ref(input alu_func_t f, input word_t a, input word_t b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return word_t'($signed(a) < $signed(b));
            ALU_SLTU: return word_t'(a < b);
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
            default:  return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // program generation
    ////////////////////////////////////////

    // biased toward recent destinations for raw chains
    function automatic reg_idx_t pick_reg();
        int unsigned r;
        r = $urandom_range(99);
        if (r < 10) begin
            return '0;
        end
        if (r < 60) begin
            return recent[2'($urandom)];
        end
        return reg_idx_t'($urandom);
    endfunction

    task automatic gen_inst(output word_t w, output logic ill);
        int unsigned kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        kind = $urandom_range(99);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'($urandom_range(7));
        ill  = 1'b0;
        if (kind < 40) begin
            w = {12'($urandom), rs1, f3, rd, 7'b0010011};
            // shifts need a legal funct7
            if (f3 == 3'b001) begin
                w[31:25] = 7'b0;
            end
            if (f3 == 3'b101) begin
                w[31:25] = {1'b0, 1'($urandom), 5'b0};
            end
        end else if (kind < 75) begin
            w = {7'b0, rs2, rs1, f3, rd, 7'b0110011};
            if (f3 == 3'b000 || f3 == 3'b101) begin
                w[30] = 1'($urandom);
            end
        end else if (kind < 92) begin
            w = {20'($urandom), rd, (kind < 84) ? 7'b0110111 : 7'b0010111};
        end else begin
            // mul, load or branch encodings
            ill = 1'b1;
            w = {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
            if (kind < 97) begin
                w[6:0] = (kind < 95) ? 7'b0000011 : 7'b1100011;
            end
        end
        recent[recent_ptr] = rd;
        recent_ptr = recent_ptr + 1'b1;
    endtask

    ////////////////////////////////////////
    // stimulus and end of run
    ////////////////////////////////////////

    initial begin
        word_t w;
        logic  ill;
        logic  v;
        logic  taken;
        word_t res;
        word_t cur_pc;
        int    idx;
        void'($urandom(32'hd9c1e89e));
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        cur_pc     = 32'h0000_1000;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        check_value("issue_valid", 32'(issue_valid), 32'd0);
        check_value("retire_valid", 32'(retire_valid), 32'd0);

        for (idx = 0; idx < PROG_LEN; idx++) begin
            slow = (idx >= PROG_LEN / 2);
            gen_inst(w, ill);
            // hold the word until the stage takes it
            do begin
                @(negedge clock);
                v          = ($urandom_range(99) < 85);
                inst_valid = v;
                inst       = w;
                pc         = cur_pc;
                taken      = v && (dispatch_ready || ill);
            end while (!taken);
            if (ill) begin
                n_illegal++;
            end else begin
                res = isa_result(w, cur_pc);
                exp_rd_q.push_back(w[11:7]);
                exp_val_q.push_back(res);
                if (w[11:7] != 5'd0) begin
                    shadow[w[11:7]] = res;
                end
                n_legal++;
            end
            cur_pc = cur_pc + 32'd4;
        end
        @(negedge clock);
        inst_valid = 1'b0;

        while (retire_count < n_legal) begin
            @(negedge clock);
        end
        repeat (20) @(negedge clock);
        check_value("retire_count", 32'(retire_count), 32'(n_legal));
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);

        $display("retired %0d of %0d legal, %0d illegal dropped, %0d errors",
                 retire_count, n_legal, n_illegal, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // functional unit, accepts under random stalls and broadcasts later
    initial begin
        int          cycle;
        int unsigned busy_pct;
        int unsigned max_delay;
        logic        busy;
        cycle     = 0;
        fu_busy   = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_value = '0;
        forever begin
            @(negedge clock);
            cycle++;
            busy_pct  = slow ? 50 : 10;
            max_delay = slow ? SLOW_DELAY : FAST_DELAY;
            cdb_valid = 1'b0;
            if (res_due_q.size() > 0 && res_due_q[0] <= cycle) begin
                cdb_valid = 1'b1;
                cdb_tag   = res_tag_q.pop_front();
                cdb_value = res_val_q.pop_front();
                void'(res_due_q.pop_front());
            end
            busy    = ($urandom_range(99) < busy_pct);
            fu_busy = busy;
            if (!rst && issue_valid && !busy) begin
                res_tag_q.push_back(issue_tag);
                res_val_q.push_back(alu_ref(issue_func, issue_opa, issue_opb));
                res_due_q.push_back(cycle + 1 + int'($urandom_range(max_delay)));
            end
        end
    end

    // retire compare, the head leaves at the next rising edge
    initial begin
        forever begin
            @(negedge clock);
            if (!rst && retire_valid) begin
                if (exp_rd_q.size() == 0) begin
                    errors++;
                    $display("retire seen with no instruction in flight at %0t", $time);
                end else begin
                    check_value("retire_rd", 32'(retire_rd), 32'(exp_rd_q.pop_front()));
                    check_value("retire_value", retire_value, exp_val_q.pop_front());
                end
                retire_count++;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout, only %0d of %0d instructions retired", retire_count, n_legal);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/dispatch_stage_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_stage_props import ooo_pkg::*; (
    input logic      clock,
    input logic      rst,
    input logic      fu_busy,
    input logic      dispatch_ready,
    input logic      do_dispatch,
    input logic      retire_valid,
    input logic      issue_valid,
    input word_t     issue_opa,
    input word_t     issue_opb,
    input alu_func_t issue_func,
    input rob_tag_t  issue_tag
);

    localparam int CNT_W = `DS_ROB_TAG_W + 1;

    logic [CNT_W-1:0] in_flight;

    // rob occupancy counted from allocations and retires
    always_ff @(posedge clock) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CNT_W'(do_dispatch) - CNT_W'(retire_valid);
        end
    end

    // stalled issue keeps its payload
    a_issue_held: assert property (@(posedge clock) disable iff (rst)
        issue_valid && fu_busy |=> issue_valid && $stable(issue_opa) && $stable(issue_opb)
            && $stable(issue_func) && $stable(issue_tag))
        else $error("issue dropped or changed while the unit was busy");

    a_full_blocks: assert property (@(posedge clock) disable iff (rst)
        (in_flight == CNT_W'(`DS_ROB_DEPTH)) |-> !dispatch_ready)
        else $error("dispatch_ready high with the reorder buffer full");

endmodule

bind dispatch_stage dispatch_stage_props props_0 (
    .clock          (clock),
    .rst            (rst),
    .fu_busy        (fu_busy),
    .dispatch_ready (dispatch_ready),
    .do_dispatch    (do_dispatch),
    .retire_valid   (retire_valid),
    .issue_valid    (issue_valid),
    .issue_opa      (issue_opa),
    .issue_opb      (issue_opb),
    .issue_func     (issue_func),
    .issue_tag      (issue_tag)
);

`default_nettype wire

// ==== src/dispatch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module dispatch_stage import ooo_pkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  logic      inst_valid,
    input  word_t     inst,
    input  word_t     pc,
    output logic      dispatch_ready,
    input  logic      fu_busy,
    output logic      issue_valid,
    output word_t     issue_opa,
    output word_t     issue_opb,
    output alu_func_t issue_func,
    output rob_tag_t  issue_tag,
    input  logic      cdb_valid,
    input  rob_tag_t  cdb_tag,
    input  word_t     cdb_value,
    output logic      retire_valid,
    output reg_idx_t  retire_rd,
    output word_t     retire_value
);

    decoded_t           dec;
    logic               rob_full;
    logic               do_dispatch;
    rob_tag_t           alloc_tag;
    logic               rs1_ready, rs2_ready;
    rob_tag_t           rs1_tag, rs2_tag;
    word_t              rf_a, rf_b;
    logic               rob_done_a, rob_done_b;
    word_t              rob_val_a, rob_val_b;
    reg_idx_t           rob_retire_rd;
    logic               rob_retire_has_dest;
    rob_tag_t           rob_retire_tag;
    logic               rf_write;
    logic [`DS_XLEN:0]  opa_res, opb_res;

    rs_dispatch_if rs_if ();

    // illegal words are consumed here and never reach the rob
    assign dispatch_ready = !rob_full && rs_if.free;
    assign do_dispatch    = inst_valid && dispatch_ready && !dec.illegal;

    assign rf_write  = retire_valid && rob_retire_has_dest;
    assign retire_rd = rob_retire_has_dest ? rob_retire_rd : '0;

    ////////////////////////////////////////
    // operand selection
    ////////////////////////////////////////

    // {valid, value}, or the tag while still pending
    function automatic logic [`DS_XLEN:0] resolve(
        input logic     ready,
        input rob_tag_t tag,
        input word_t    rf_val,
        input logic     rob_done,
        input word_t    rob_val,
        input logic     bus_valid,
        input rob_tag_t bus_tag,
        input word_t    bus_value
    );
        if (ready) begin
            return {1'b1, rf_val};
        end else if (bus_valid && (bus_tag == tag)) begin
            return {1'b1, bus_value};
        end else if (rob_done) begin
            return {1'b1, rob_val};
        end
        return {1'b0, word_t'(tag)};
    endfunction

    always_comb begin
        case (dec.opa_sel)
            OPA_IS_PC:   opa_res = {1'b1, pc};
            OPA_IS_ZERO: opa_res = {1'b1, word_t'(0)};
            default:     opa_res = resolve(rs1_ready, rs1_tag, rf_a, rob_done_a, rob_val_a,
                                           cdb_valid, cdb_tag, cdb_value);
        endcase
    end

    always_comb begin
        case (dec.opb_sel)
            OPB_IS_I_IMM: opb_res = {1'b1, {20{inst[31]}}, inst[31:20]};
            OPB_IS_U_IMM: opb_res = {1'b1, inst[31:12], 12'b0};
            default:      opb_res = resolve(rs2_ready, rs2_tag, rf_b, rob_done_b, rob_val_b,
                                            cdb_valid, cdb_tag, cdb_value);
        endcase
    end

    assign rs_if.load      = do_dispatch;
    assign rs_if.opa       = opa_res[`DS_XLEN-1:0];
    assign rs_if.opa_valid = opa_res[`DS_XLEN];
    assign rs_if.opb       = opb_res[`DS_XLEN-1:0];
    assign rs_if.opb_valid = opb_res[`DS_XLEN];
    assign rs_if.alu_func  = dec.alu_func;
    assign rs_if.rob_tag   = alloc_tag;

    ////////////////////////////////////////
    // submodules
    ////////////////////////////////////////

    inst_decoder decoder_0 (
        .inst  (inst),
        .valid (inst_valid),
        .dec   (dec)
    );

    map_table map_table_0 (
        .clock      (clock),
        .rst        (rst),
        .rs1        (inst[19:15]),
        .rs2        (inst[24:20]),
        .rd         (inst[11:7]),
        .rename     (do_dispatch && dec.has_dest),
        .new_tag    (alloc_tag),
        .retire     (rf_write),
        .retire_rd  (rob_retire_rd),
        .retire_tag (rob_retire_tag),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag)
    );

    reorder_buffer rob_0 (
        .clock           (clock),
        .rst             (rst),
        .alloc           (do_dispatch),
        .alloc_rd        (inst[11:7]),
        .alloc_has_dest  (dec.has_dest),
        .alloc_tag       (alloc_tag),
        .full            (rob_full),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .rd_tag_a        (rs1_tag),
        .rd_tag_b        (rs2_tag),
        .rd_done_a       (rob_done_a),
        .rd_done_b       (rob_done_b),
        .rd_value_a      (rob_val_a),
        .rd_value_b      (rob_val_b),
        .retire_valid    (retire_valid),
        .retire_rd       (rob_retire_rd),
        .retire_has_dest (rob_retire_has_dest),
        .retire_tag      (rob_retire_tag),
        .retire_value    (retire_value)
    );

    reservation_station rs_0 (
        .clock       (clock),
        .rst         (rst),
        .dsp         (rs_if.station),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .fu_busy     (fu_busy),
        .issue_valid (issue_valid),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb),
        .issue_func  (issue_func),
        .issue_tag   (issue_tag)
    );

    regfile regfile_0 (
        .clock   (clock),
        .rd_a    (inst[19:15]),
        .rd_b    (inst[24:20]),
        .val_a   (rf_a),
        .val_b   (rf_b),
        .we      (rf_write),
        .wr_idx  (rob_retire_rd),
        .wr_data (retire_value)
    );

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module regfile import ooo_pkg::*; (
    input  logic     clock,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    output word_t    val_a,
    output word_t    val_b,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    // no storage behind x0
    word_t regs [1:`DS_NUM_REGS-1] = '{default: '0};

    assign val_a = (rd_a == '0) ? '0 : regs[rd_a];
    assign val_b = (rd_b == '0) ? '0 : regs[rd_b];

    always_ff @(posedge clock) begin
        if (we && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    rs_dispatch_if.station        dsp,
    input  logic                  cdb_valid,
    input  rob_tag_t              cdb_tag,
    input  word_t                 cdb_value,
    input  logic                  fu_busy,
    output logic                  issue_valid,
    output word_t                 issue_opa,
    output word_t                 issue_opb,
    output alu_func_t             issue_func,
    output rob_tag_t              issue_tag
);

    logic      busy;
    logic      opa_valid;
    logic      opb_valid;
    word_t     opa;
    word_t     opb;
    alu_func_t func;
    rob_tag_t  tag;
    logic      wake_a;
    logic      wake_b;

    // a pending operand holds its tag in the low bits
    assign wake_a = busy && !opa_valid && cdb_valid && (rob_tag_t'(opa) == cdb_tag);
    assign wake_b = busy && !opb_valid && cdb_valid && (rob_tag_t'(opb) == cdb_tag);

    assign dsp.free    = !busy;
    assign issue_valid = busy && opa_valid && opb_valid;
    assign issue_opa   = opa;
    assign issue_opb   = opb;
    assign issue_func  = func;
    assign issue_tag   = tag;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy      <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else if (dsp.load) begin
            busy      <= 1'b1;
            opa_valid <= dsp.opa_valid;
            opb_valid <= dsp.opb_valid;
        end else begin
            // unit took it, entry frees
            if (issue_valid && !fu_busy) begin
                busy <= 1'b0;
            end
            if (wake_a) begin
                opa_valid <= 1'b1;
            end
            if (wake_b) begin
                opb_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dsp.load) begin
            opa  <= dsp.opa;
            opb  <= dsp.opb;
            func <= dsp.alu_func;
            tag  <= dsp.rob_tag;
        end else begin
            if (wake_a) begin
                opa <= cdb_value;
            end
            if (wake_b) begin
                opb <= cdb_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    input  logic     alloc_has_dest,
    output rob_tag_t alloc_tag,
    output logic     full,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    input  rob_tag_t rd_tag_a,
    input  rob_tag_t rd_tag_b,
    output logic     rd_done_a,
    output logic     rd_done_b,
    output word_t    rd_value_a,
    output word_t    rd_value_b,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output logic     retire_has_dest,
    output rob_tag_t retire_tag,
    output word_t    retire_value
);

    reg_idx_t                 ent_rd       [`DS_ROB_DEPTH];
    logic                     ent_has_dest [`DS_ROB_DEPTH];
    word_t                    ent_value    [`DS_ROB_DEPTH];
    logic [`DS_ROB_DEPTH-1:0] ent_done;

    rob_tag_t               head;
    rob_tag_t               tail;
    logic [`DS_ROB_TAG_W:0] count;
    logic                   pop;

    assign full      = (count == (`DS_ROB_TAG_W + 1)'(`DS_ROB_DEPTH));
    assign alloc_tag = tail;

    ////////////////////////////////////////
    // retire port
    ////////////////////////////////////////

    // head leaves once its result has come back
    assign retire_valid    = (count != '0) && ent_done[head];
    assign pop             = retire_valid;
    assign retire_rd       = ent_rd[head];
    assign retire_has_dest = ent_has_dest[head];
    assign retire_tag      = head;
    assign retire_value    = ent_value[head];

    // operand reads for dispatch
    assign rd_done_a  = ent_done[rd_tag_a];
    assign rd_done_b  = ent_done[rd_tag_b];
    assign rd_value_a = ent_value[rd_tag_a];
    assign rd_value_b = ent_value[rd_tag_b];

    ////////////////////////////////////////
    // pointers and completion
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else begin
            if (alloc) begin
                tail           <= tail + 1'b1;
                ent_done[tail] <= 1'b0;
            end
            if (cdb_valid) begin
                ent_done[cdb_tag] <= 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({alloc, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            ent_rd[tail]       <= alloc_rd;
            ent_has_dest[tail] <= alloc_has_dest;
        end
        if (cdb_valid) begin
            ent_value[cdb_tag] <= cdb_value;
        end
    end

endmodule

`default_nettype wire

// ==== src/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_cfg.svh"

module map_table import ooo_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     rename,
    input  rob_tag_t new_tag,
    input  logic     retire,
    input  reg_idx_t retire_rd,
    input  rob_tag_t retire_tag,
    output logic     rs1_ready,
    output logic     rs2_ready,
    output rob_tag_t rs1_tag,
    output rob_tag_t rs2_tag
);

    // ready means the value sits in the register file
    logic [`DS_NUM_REGS-1:0] ready;
    rob_tag_t                tags [`DS_NUM_REGS];

    assign rs1_ready = ready[rs1];
    assign rs2_ready = ready[rs2];
    assign rs1_tag   = tags[rs1];
    assign rs2_tag   = tags[rs2];

    // x0 is never renamed, so its ready bit stays set
    always_ff @(posedge clock) begin
        if (rst) begin
            ready <= '1;
        end else begin
            if (retire && (tags[retire_rd] == retire_tag)) begin
                ready[retire_rd] <= 1'b1;
            end
            // rename after retire so it wins on the same register
            if (rename && (rd != '0)) begin
                ready[rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rename && (rd != '0)) begin
            tags[rd] <= new_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import ooo_pkg::*; (
    input  word_t    inst,
    input  logic     valid,
    output decoded_t dec
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // inactive result, looks like a bubble
        dec.opa_sel  = OPA_IS_RS1;
        dec.opb_sel  = OPB_IS_RS2;
        dec.alu_func = ALU_ADD;
        dec.has_dest = 1'b0;
        dec.illegal  = 1'b0;

        if (valid) begin
            dec.has_dest = 1'b1;
            case (opcode)
                OPC_LUI: begin
                    dec.opa_sel = OPA_IS_ZERO;
                    dec.opb_sel = OPB_IS_U_IMM;
                end
                OPC_AUIPC: begin
                    dec.opa_sel = OPA_IS_PC;
                    dec.opb_sel = OPB_IS_U_IMM;
                end
                OPC_OP_IMM: begin
                    dec.opb_sel = OPB_IS_I_IMM;
                    case (funct3)
                        3'b000: dec.alu_func = ALU_ADD;
                        3'b010: dec.alu_func = ALU_SLT;
                        3'b011: dec.alu_func = ALU_SLTU;
                        3'b100: dec.alu_func = ALU_XOR;
                        3'b110: dec.alu_func = ALU_OR;
                        3'b111: dec.alu_func = ALU_AND;
                        3'b001: begin
                            dec.alu_func = ALU_SLL;
                            dec.illegal  = (funct7 != 7'b0000000);
                        end
                        default: begin
                            // srli / srai, bit 30 picks arithmetic
                            dec.alu_func = funct7[5] ? ALU_SRA : ALU_SRL;
                            dec.illegal  = ({funct7[6], funct7[4:0]} != 6'b0);
                        end
                    endcase
                end
                OPC_OP: begin
                    case ({funct7, funct3})
                        10'b0000000_000: dec.alu_func = ALU_ADD;
                        10'b0100000_000: dec.alu_func = ALU_SUB;
                        10'b0000000_001: dec.alu_func = ALU_SLL;
                        10'b0000000_010: dec.alu_func = ALU_SLT;
                        10'b0000000_011: dec.alu_func = ALU_SLTU;
                        10'b0000000_100: dec.alu_func = ALU_XOR;
                        10'b0000000_101: dec.alu_func = ALU_SRL;
                        10'b0100000_101: dec.alu_func = ALU_SRA;
                        10'b0000000_110: dec.alu_func = ALU_OR;
                        10'b0000000_111: dec.alu_func = ALU_AND;
                        default:         dec.illegal  = 1'b1;
                    endcase
                end
                default: dec.illegal = 1'b1;
            endcase

            // dropped words and x0 writes leave no destination
            if (dec.illegal || (inst[11:7] == 5'd0)) begin
                dec.has_dest = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/rs_dispatch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rs_dispatch_if import ooo_pkg::*; ();

    // an operand with its valid low carries the producing rob tag in its low bits
    logic      load;
    word_t     opa;
    logic      opa_valid;
    word_t     opb;
    logic      opb_valid;
    alu_func_t alu_func;
    rob_tag_t  rob_tag;

    // station empty, load allowed
    logic      free;

    modport dispatcher (
        output load, opa, opa_valid, opb, opb_valid, alu_func, rob_tag,
        input  free
    );

    modport station (
        input  load, opa, opa_valid, opb, opb_valid, alu_func, rob_tag,
        output free
    );

endinterface

`default_nettype wire

// ==== common/ooo_pkg.sv ====
`default_nettype none

`include "dispatch_cfg.svh"

package ooo_pkg;

    typedef logic [`DS_XLEN-1:0]      word_t;
    typedef logic [`DS_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`DS_ROB_TAG_W-1:0] rob_tag_t;

    // operation handed to the functional unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_t;

    typedef enum logic [1:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_U_IMM
    } opb_sel_t;

    // control fields out of the decoder
    typedef struct packed {
        opa_sel_t  opa_sel;
        opb_sel_t  opb_sel;
        alu_func_t alu_func;
        logic      has_dest;
        logic      illegal;
    } decoded_t;

endpackage

`default_nettype wire

// ==== common/dispatch_cfg.svh ====
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// datapath width
`define DS_XLEN 32

// architectural register file
`define DS_NUM_REGS 32
`define DS_REG_IDX_W 5

// reorder buffer, depth must be a power of two
`define DS_ROB_DEPTH 8
`define DS_ROB_TAG_W 3

`endif
